// ==== src.f ====
rtl/tri_inv_pkg.sv
rtl/mat_store.sv
rtl/cplx_recip.sv
rtl/cplx_dot.sv
rtl/tri_inv_ctrl.sv
rtl/tri_inv_top.sv
tb/tb_tri_inv.sv

// ==== tb/tb_tri_inv.sv ====
module tb_tri_inv import tri_inv_pkg::*; ();

  localparam int VW         = $bits(row_vec_t);
  localparam int WAIT_LIMIT = 4000;  // cycles per wait

  logic     clk_i;
  logic     rst_ni;
  logic     wr_en_i;
  wr_req_t  wr_i;
  logic     start_i;
  logic     col_ack_i;
  logic     busy_o;
  logic     singular_o;
  logic     col_req_o;
  idx_t     col_addr_o;
  row_vec_t col_o;

  integer   seed;
  int       err_cnt;
  int       n_ok;
  int       n_bad;
  int       errs_at;
  cplx_t    mat [SIZE][SIZE];
  row_vec_t exp_cols [SIZE];
  row_vec_t got_cols [SIZE];

  tri_inv_top dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (wr_en_i),
    .wr_i       (wr_i),
    .start_i    (start_i),
    .busy_o     (busy_o),
    .singular_o (singular_o),
    .col_req_o  (col_req_o),
    .col_addr_o (col_addr_o),
    .col_o      (col_o),
    .col_ack_i  (col_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic int pick(input int hi);
    return int'($unsigned($random(seed)) % (hi + 1));
  endfunction

  function automatic cplx_t mk(input int re, input int im);
    cplx_t v;
    v.re = elem_t'(re);
    v.im = elem_t'(im);
    return v;
  endfunction

  // low half of the 32-bit products
  function automatic cplx_t cx_mul(input cplx_t a, input cplx_t b);
    int ar, ai, br, bi;
    ar = a.re;
    ai = a.im;
    br = b.re;
    bi = b.im;
    return mk(ar * br - ai * bi, ar * bi + ai * br);
  endfunction

  function automatic cplx_t cx_add(input cplx_t a, input cplx_t b);
    return mk(int'(a.re) + int'(b.re), int'(a.im) + int'(b.im));
  endfunction

  // conj(d) / |d|^2 with each part truncated toward zero
  function automatic cplx_t recip_of(input cplx_t d);
    longint a, b;
    norm_t  nrm;
    a   = d.re;
    b   = d.im;
    nrm = norm_t'(a * a + b * b);
    if (nrm == '0) begin
      return '0;
    end
    return mk(int'(a / longint'(nrm)), int'((-b) / longint'(nrm)));
  endfunction

  task automatic check_eq(input string name, input logic [VW-1:0] exp_v,
                          input logic [VW-1:0] got_v);
    assert (got_v === exp_v) else begin
      $display("CHECK FAILED %s: expected %0h, got %0h", name, exp_v, got_v);
      err_cnt++;
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == errs_at) begin
      n_ok++;
      $display("%s: ok", name);
    end else begin
      n_bad++;
      $display("%s: %0d errors", name, err_cnt - errs_at);
    end
    errs_at = err_cnt;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic make_identity();
    for (int r = 0; r < SIZE; r++) begin
      for (int c = 0; c < SIZE; c++) begin
        mat[r][c] = mk((r == c) ? 1 : 0, 0);
      end
    end
  endtask

  // unit-type diagonal with small values below and zeros above
  task automatic make_random(input int zero_row);
    int sel;
    for (int r = 0; r < SIZE; r++) begin
      for (int c = 0; c < SIZE; c++) begin
        if (c > r) begin
          mat[r][c] = '0;
        end else if (c < r) begin
          mat[r][c] = mk(pick(6) - 3, pick(6) - 3);
        end else begin
          sel = pick(3);
          case (sel)
            0:       mat[r][c] = mk(1, 0);
            1:       mat[r][c] = mk(-1, 0);
            2:       mat[r][c] = mk(0, 1);
            default: mat[r][c] = mk(0, -1);
          endcase
          if (r == zero_row) begin
            mat[r][c] = '0;
          end
        end
      end
    end
  endtask

  // upper zeros are written too
  task automatic load_matrix();
    for (int r = 0; r < SIZE; r++) begin
      for (int c = 0; c < SIZE; c++) begin
        wr_en_i     = 1'b1;
        wr_i.row    = idx_t'(r);
        wr_i.col    = idx_t'(c);
        wr_i.data   = mat[r][c];
        @(negedge clk_i);
      end
    end
    wr_en_i = 1'b0;
  endtask

  // X[i][j] = -(sum of L[i][k] * X[k][j]) * 1/L[i][i]
  task automatic model_inverse();
    row_vec_t col;
    cplx_t    acc;
    for (int j = 0; j < SIZE; j++) begin
      col    = '0;
      col[j] = recip_of(mat[j][j]);
      for (int i = j + 1; i < SIZE; i++) begin
        acc = '0;
        for (int k = j; k < i; k++) begin
          acc = cx_add(acc, cx_mul(mat[i][k], col[k]));
        end
        col[i] = cx_mul(mk(-int'(acc.re), -int'(acc.im)), recip_of(mat[i][i]));
      end
      exp_cols[j] = col;
    end
  endtask

  // start pulse and column handshakes with random ack delays
  task automatic run_inverse(input int max_delay);
    int       n;
    int       hold;
    row_vec_t seen;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    check_eq("busy_o", 1'b1, busy_o);
    check_eq("singular_o", 1'b0, singular_o);
    for (int c = 0; c < SIZE; c++) begin
      n = 0;
      while (!col_req_o) begin
        if (n == WAIT_LIMIT) give_up("col_req_o to rise");
        @(negedge clk_i);
        n++;
      end
      seen = col_o;
      check_eq("col_addr_o", c, col_addr_o);
      hold = pick(max_delay);
      repeat (hold) begin
        @(negedge clk_i);
        check_eq("col_req_o", 1'b1, col_req_o);
        check_eq("col_o", seen, col_o);
      end
      col_ack_i = 1'b1;
      n = 0;
      while (col_req_o) begin
        if (n == WAIT_LIMIT) give_up("col_req_o to fall");
        check_eq("col_o", seen, col_o);
        @(negedge clk_i);
        n++;
      end
      got_cols[c] = seen;
      hold = pick(max_delay);
      repeat (hold) begin
        @(negedge clk_i);
        check_eq("col_req_o", 1'b0, col_req_o);  // ack still high
        check_eq("busy_o", 1'b1, busy_o);
      end
      col_ack_i = 1'b0;
    end
    @(negedge clk_i);
    check_eq("busy_o", 1'b0, busy_o);
  endtask

  task automatic check_columns();
    for (int j = 0; j < SIZE; j++) begin
      for (int i = 0; i < SIZE; i++) begin
        check_eq($sformatf("col_o[%0d] of column %0d", i, j), exp_cols[j][i], got_cols[j][i]);
        if (i < j) begin
          check_eq($sformatf("col_o[%0d] of column %0d", i, j), '0, got_cols[j][i]);
        end
      end
    end
  endtask

  task automatic check_product();
    cplx_t acc;
    for (int r = 0; r < SIZE; r++) begin
      for (int c = 0; c < SIZE; c++) begin
        acc = '0;
        for (int k = 0; k < SIZE; k++) begin
          acc = cx_add(acc, cx_mul(mat[r][k], got_cols[c][k]));
        end
        check_eq($sformatf("product[%0d][%0d]", r, c), mk((r == c) ? 1 : 0, 0), acc);
      end
    end
  endtask

  initial begin
    int n;
    seed      = 76978;
    err_cnt   = 0;
    n_ok      = 0;
    n_bad     = 0;
    errs_at   = 0;
    rst_ni    = 1'b0;
    wr_en_i   = 1'b0;
    wr_i      = '0;
    start_i   = 1'b0;
    col_ack_i = 1'b0;
    apply_reset();

    make_identity();
    load_matrix();
    run_inverse(0);
    for (int j = 0; j < SIZE; j++) begin
      for (int i = 0; i < SIZE; i++) begin
        check_eq($sformatf("col_o[%0d] of column %0d", i, j),
                 mk((i == j) ? 1 : 0, 0), got_cols[j][i]);
      end
    end
    check_eq("singular_o", 1'b0, singular_o);
    finish_test("test 1 identity");

    make_random(-1);
    load_matrix();
    model_inverse();
    run_inverse(0);
    check_columns();
    finish_test("test 2 random matrix");

    check_product();
    finish_test("test 3 product");

    run_inverse(7);  // same matrix with late acks
    check_columns();
    finish_test("test 4 back-pressure");

    make_random(1);
    load_matrix();
    model_inverse();
    run_inverse(3);
    check_eq("singular_o", 1'b1, singular_o);
    check_columns();
    make_random(-1);
    load_matrix();
    model_inverse();
    run_inverse(2);
    check_eq("singular_o", 1'b0, singular_o);
    check_columns();
    finish_test("test 5 zero diagonal");

    // reset while a singular run offers its first column
    make_random(0);
    load_matrix();
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    n = 0;
    while (!col_req_o) begin
      if (n == WAIT_LIMIT) give_up("col_req_o to rise");
      @(negedge clk_i);
      n++;
    end
    check_eq("singular_o", 1'b1, singular_o);
    check_eq("busy_o", 1'b1, busy_o);
    apply_reset();
    check_eq("col_req_o", 1'b0, col_req_o);
    check_eq("busy_o", 1'b0, busy_o);
    check_eq("singular_o", 1'b0, singular_o);
    make_random(-1);
    load_matrix();
    model_inverse();
    run_inverse(1);
    check_columns();
    finish_test("test 6 control after reset");

    $display("tests ok: %0d, tests with errors: %0d", n_ok, n_bad);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== rtl/tri_inv_top.sv ====
module tri_inv_top import tri_inv_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wr_en_i,
  input  wr_req_t  wr_i,
  input  logic     start_i,
  output logic     busy_o,
  output logic     singular_o,
  output logic     col_req_o,
  output idx_t     col_addr_o,
  output row_vec_t col_o,
  input  logic     col_ack_i
);

  logic     row_req, row_ack;
  idx_t     row_addr;
  row_vec_t row_data;
  logic     recip_start, recip_done, recip_zero;
  cplx_t    recip_d, recip_q;
  logic     dot_valid, dot_out_valid;
  row_vec_t dot_row, dot_col;
  cplx_t    dot_scale, dot_out;

  mat_store u_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (wr_en_i),
    .wr_i       (wr_i),
    .row_req_i  (row_req),
    .row_addr_i (row_addr),
    .row_ack_o  (row_ack),
    .row_data_o (row_data)
  );

  cplx_recip u_recip (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (recip_start),
    .d_i     (recip_d),
    .done_o  (recip_done),
    .q_o     (recip_q),
    .zero_o  (recip_zero)
  );

  cplx_dot u_dot (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (dot_valid),
    .row_i   (dot_row),
    .col_i   (dot_col),
    .scale_i (dot_scale),
    .valid_o (dot_out_valid),
    .res_o   (dot_out)
  );

  tri_inv_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .busy_o        (busy_o),
    .singular_o    (singular_o),
    .row_req_o     (row_req),
    .row_addr_o    (row_addr),
    .row_ack_i     (row_ack),
    .row_data_i    (row_data),
    .recip_start_o (recip_start),
    .recip_d_o     (recip_d),
    .recip_done_i  (recip_done),
    .recip_q_i     (recip_q),
    .recip_zero_i  (recip_zero),
    .dot_valid_o   (dot_valid),
    .dot_row_o     (dot_row),
    .dot_col_o     (dot_col),
    .dot_scale_o   (dot_scale),
    .dot_valid_i   (dot_out_valid),
    .dot_res_i     (dot_out),
    .col_req_o     (col_req_o),
    .col_addr_o    (col_addr_o),
    .col_o         (col_o),
    .col_ack_i     (col_ack_i)
  );

endmodule

// ==== rtl/tri_inv_ctrl.sv ====
module tri_inv_ctrl import tri_inv_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  output logic     busy_o,
  output logic     singular_o,

  // row fetch
  output logic     row_req_o,
  output idx_t     row_addr_o,
  input  logic     row_ack_i,
  input  row_vec_t row_data_i,

  // reciprocal unit
  output logic     recip_start_o,
  output cplx_t    recip_d_o,
  input  logic     recip_done_i,
  input  cplx_t    recip_q_i,
  input  logic     recip_zero_i,

  // dot pipeline
  output logic     dot_valid_o,
  output row_vec_t dot_row_o,
  output row_vec_t dot_col_o,
  output cplx_t    dot_scale_o,
  input  logic     dot_valid_i,
  input  cplx_t    dot_res_i,

  // column output
  output logic     col_req_o,
  output idx_t     col_addr_o,
  output row_vec_t col_o,
  input  logic     col_ack_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_DIAG_FETCH,
    S_RECIP_WAIT,
    S_COL_SEED,
    S_ROW_FETCH,
    S_DRAIN,
    S_OUT
  } state_t;

  state_t   state_q;
  idx_t     row_idx_q;   // row being fetched
  idx_t     col_idx_q;   // column being built
  idx_t     wr_ptr_q;    // row of the next dot result
  row_vec_t col_q;
  row_vec_t diag_buf_q;  // 1/L[i][i]
  logic     pend_q;      // dot result outstanding
  logic     row_have_q;  // fetched row not yet issued
  logic     col_sent_q;

  logic     row_hit;
  logic     fetch_go;
  logic     issue;
  logic     last_row;
  logic     last_col;
  logic     col_fin;

  assign row_hit  = row_req_o && row_ack_i;
  assign last_row = (row_idx_q == idx_t'(SIZE - 1));
  assign last_col = (col_idx_q == idx_t'(SIZE - 1));
  assign fetch_go = !row_req_o && !row_ack_i &&
                    ((state_q == S_DIAG_FETCH) || (state_q == S_ROW_FETCH && !row_have_q));
  // the previous row's result must be in the column first
  assign issue    = (state_q == S_ROW_FETCH) && row_have_q && (!pend_q || dot_valid_i);
  assign col_fin  = (state_q == S_OUT) && col_sent_q && !col_ack_i;

  assign row_addr_o = row_idx_q;
  assign dot_col_o  = col_q;
  assign col_o      = col_q;
  assign col_addr_o = col_idx_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= S_IDLE;
      busy_o        <= 1'b0;
      singular_o    <= 1'b0;
      row_req_o     <= 1'b0;
      recip_start_o <= 1'b0;
      dot_valid_o   <= 1'b0;
      col_req_o     <= 1'b0;
      pend_q        <= 1'b0;
      row_have_q    <= 1'b0;
      col_sent_q    <= 1'b0;
    end else begin
      recip_start_o <= 1'b0;
      dot_valid_o   <= 1'b0;

      if (fetch_go) begin
        row_req_o <= 1'b1;
      end else if (row_hit) begin
        row_req_o <= 1'b0;
      end

      if (dot_valid_i) begin
        pend_q <= 1'b0;
      end
      if (issue) begin
        pend_q <= 1'b1;
      end

      if (state_q == S_ROW_FETCH && row_hit) begin
        row_have_q <= 1'b1;
      end else if (issue) begin
        row_have_q <= 1'b0;
      end

      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            busy_o     <= 1'b1;
            singular_o <= 1'b0;
            state_q    <= S_DIAG_FETCH;
          end
        end
        S_DIAG_FETCH: begin
          if (row_hit) begin
            recip_start_o <= 1'b1;
            state_q       <= S_RECIP_WAIT;
          end
        end
        S_RECIP_WAIT: begin
          if (recip_done_i) begin
            if (recip_zero_i) begin
              singular_o <= 1'b1;  // sticky until next start
            end
            state_q <= last_row ? S_COL_SEED : S_DIAG_FETCH;
          end
        end
        S_COL_SEED: begin
          state_q <= last_col ? S_OUT : S_ROW_FETCH;
        end
        S_ROW_FETCH: begin
          if (issue) begin
            dot_valid_o <= 1'b1;
            if (last_row) begin
              state_q <= S_DRAIN;
            end
          end
        end
        S_DRAIN: begin
          if (!pend_q) begin
            state_q <= S_OUT;
          end
        end
        S_OUT: begin
          if (!col_req_o && !col_ack_i && !col_sent_q) begin
            col_req_o <= 1'b1;
          end else if (col_req_o && col_ack_i) begin
            col_req_o  <= 1'b0;
            col_sent_q <= 1'b1;
          end
          if (col_fin) begin
            col_sent_q <= 1'b0;
            if (last_col) begin
              busy_o  <= 1'b0;
              state_q <= S_IDLE;
            end else begin
              state_q <= S_COL_SEED;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && start_i) begin
      row_idx_q <= '0;
    end
    if (state_q == S_DIAG_FETCH && row_hit) begin
      recip_d_o <= row_data_i[row_idx_q];
    end
    if (state_q == S_RECIP_WAIT && recip_done_i) begin
      diag_buf_q[row_idx_q] <= recip_q_i;
      if (last_row) begin
        col_idx_q <= '0;
      end else begin
        row_idx_q <= row_idx_q + 1'b1;
      end
    end
    if (state_q == S_COL_SEED) begin
      col_q            <= '0;
      col_q[col_idx_q] <= diag_buf_q[col_idx_q];  // X[j][j]
      row_idx_q        <= col_idx_q + 1'b1;
      wr_ptr_q         <= col_idx_q + 1'b1;
    end
    if (state_q == S_ROW_FETCH && row_hit) begin
      dot_row_o <= row_data_i;
    end
    if (issue) begin
      dot_scale_o <= diag_buf_q[row_idx_q];
      if (!last_row) begin
        row_idx_q <= row_idx_q + 1'b1;
      end
    end
    if (dot_valid_i) begin
      col_q[wr_ptr_q] <= dot_res_i;  // results return in issue order
      wr_ptr_q        <= wr_ptr_q + 1'b1;
    end
    if (col_fin && !last_col) begin
      col_idx_q <= col_idx_q + 1'b1;
    end
  end

endmodule

// ==== rtl/cplx_dot.sv ====
module cplx_dot import tri_inv_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  row_vec_t row_i,
  input  row_vec_t col_i,
  input  cplx_t    scale_i,
  output logic     valid_o,
  output cplx_t    res_o
);

  row_vec_t prod_q;
  cplx_t    sum_d, sum_q;
  cplx_t    neg_w;
  cplx_t    scale_q1, scale_q2;
  logic     v1_q, v2_q;

  // wraps to ELEM_W per component
  function automatic cplx_t cmul(input cplx_t a, input cplx_t b);
    cplx_t p;
    p.re = a.re * b.re - a.im * b.im;
    p.im = a.re * b.im + a.im * b.re;
    return p;
  endfunction

  always_comb begin
    sum_d = '0;
    for (int k = 0; k < SIZE; k++) begin
      sum_d.re = sum_d.re + prod_q[k].re;
      sum_d.im = sum_d.im + prod_q[k].im;
    end
  end

  assign neg_w.re = -sum_q.re;
  assign neg_w.im = -sum_q.im;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      v1_q    <= 1'b0;
      v2_q    <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      v1_q    <= valid_i;
      v2_q    <= v1_q;
      valid_o <= v2_q;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < SIZE; k++) begin
      prod_q[k] <= cmul(row_i[k], col_i[k]);  // stage 1
    end
    scale_q1 <= scale_i;
    sum_q    <= sum_d;                        // stage 2
    scale_q2 <= scale_q1;
    res_o    <= cmul(neg_w, scale_q2);        // stage 3
  end

endmodule

// ==== rtl/cplx_recip.sv ====
module cplx_recip import tri_inv_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  input  cplx_t d_i,
  output logic  done_o,
  output cplx_t q_o,
  output logic  zero_o
);

  logic signed [2*ELEM_W-1:0] sq_re;
  logic signed [2*ELEM_W-1:0] sq_im;
  norm_t                      n_w;
  logic signed [DIV_W-1:0]    num_re;  // real part, sign extended
  logic signed [DIV_W-1:0]    num_im;  // negated imaginary part
  norm_t                      den_q;
  logic [REM_W-1:0]           rem_re_q, rem_im_q, rem_re_d, rem_im_d;
  logic [DIV_W-1:0]           qn_re_q, qn_im_q, qn_re_d, qn_im_d;
  logic                       neg_re_q, neg_im_q;
  logic                       run_q;
  logic [CNT_W-1:0]           cnt_q;
  logic                       stepping;
  logic                       finish;
  elem_t                      quot_re, quot_im;

  function automatic logic [DIV_W-1:0] mag(input logic signed [DIV_W-1:0] x);
    return x[DIV_W-1] ? -x : x;
  endfunction

  // one restoring step, dividend bits shift out of qn as quotient bits shift in
  function automatic logic [REM_W+DIV_W-1:0] div_step(input logic [REM_W-1:0] rem,
                                                      input logic [DIV_W-1:0] qn,
                                                      input norm_t            den);
    logic [REM_W-1:0] trial;
    trial = {rem[REM_W-2:0], qn[DIV_W-1]};
    if (trial >= REM_W'(den)) begin
      return {trial - REM_W'(den), qn[DIV_W-2:0], 1'b1};
    end
    return {trial, qn[DIV_W-2:0], 1'b0};
  endfunction

  assign sq_re  = d_i.re * d_i.re;
  assign sq_im  = d_i.im * d_i.im;
  assign n_w    = sq_re + sq_im;
  assign num_re = d_i.re;
  assign num_im = -d_i.im;

  assign {rem_re_d, qn_re_d} = div_step(rem_re_q, qn_re_q, den_q);
  assign {rem_im_d, qn_im_d} = div_step(rem_im_q, qn_im_q, den_q);

  assign stepping = run_q && (cnt_q < CNT_W'(DIV_W));
  assign finish   = run_q && (cnt_q == CNT_W'(DIV_W));
  assign quot_re  = elem_t'(qn_re_q[ELEM_W-1:0]);
  assign quot_im  = elem_t'(qn_im_q[ELEM_W-1:0]);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (finish) begin
          run_q  <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      den_q    <= n_w;
      zero_o   <= (n_w == '0);
      neg_re_q <= num_re[DIV_W-1];
      neg_im_q <= num_im[DIV_W-1];
      rem_re_q <= '0;
      rem_im_q <= '0;
      qn_re_q  <= mag(num_re);
      qn_im_q  <= mag(num_im);
    end else if (stepping) begin
      rem_re_q <= rem_re_d;
      rem_im_q <= rem_im_d;
      qn_re_q  <= qn_re_d;
      qn_im_q  <= qn_im_d;
    end
    if (finish) begin
      if (zero_o) begin
        q_o <= '0;
      end else begin
        q_o.re <= neg_re_q ? -quot_re : quot_re;  // truncates toward zero
        q_o.im <= neg_im_q ? -quot_im : quot_im;
      end
    end
  end

endmodule

// ==== rtl/mat_store.sv ====
module mat_store import tri_inv_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // host side
  input  logic     wr_en_i,
  input  wr_req_t  wr_i,

  // four-phase row fetch
  input  logic     row_req_i,
  input  idx_t     row_addr_i,
  output logic     row_ack_o,
  output row_vec_t row_data_o
);

  row_vec_t mem_q [SIZE];
  logic     take;

  assign take = row_req_i && !row_ack_o;  // new request seen

  // single entry per host write
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_i.row][wr_i.col] <= wr_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      row_ack_o <= 1'b0;
    end else if (take) begin
      row_ack_o <= 1'b1;
    end else if (!row_req_i && row_ack_o) begin
      row_ack_o <= 1'b0;  // return to zero
    end
  end

  // row is registered on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (take) begin
      row_data_o <= mem_q[row_addr_i];
    end
  end

endmodule

// ==== rtl/tri_inv_pkg.sv ====
package tri_inv_pkg;

  localparam int SIZE   = 4;
  localparam int ELEM_W = 16;
  localparam int IDX_W  = 2;

  // restoring divider sizing for the reciprocal
  localparam int DIV_W = ELEM_W + 1;         // magnitude of a component, -32768 included
  localparam int REM_W = 2 * ELEM_W + 1;     // partial remainder
  localparam int CNT_W = $clog2(DIV_W + 1);  // step counter

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic [IDX_W-1:0]         idx_t;
  typedef logic [2*ELEM_W-1:0]      norm_t;  // a*a + b*b, unsigned

  // im in the upper half, re in the lower half
  typedef struct packed {
    elem_t im;
    elem_t re;
  } cplx_t;

  // entry 0 sits at the low end
  typedef cplx_t [SIZE-1:0] row_vec_t;

  typedef struct packed {
    idx_t  row;
    idx_t  col;
    cplx_t data;
  } wr_req_t;

endpackage
